// ==== verilog/lstm_pkg.sv ====
`default_nettype none

package lstm_pkg;

    typedef logic signed [7:0]  data_t;
    typedef logic signed [31:0] acc_t;
    // element 0 sits in bits 7:0
    typedef logic [31:0]        vec_t;
    typedef logic [3:0]         step_t;

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } ctrl_state_t;

    localparam int CTRL_STEPS = 11;

    // steps 0..3 build the dot products
    localparam step_t STEP_LOOK_I = 4'd4;
    localparam step_t STEP_LOOK_Z = 4'd5;
    localparam step_t STEP_LOOK_F = 4'd6;
    localparam step_t STEP_CELL   = 4'd7;
    localparam step_t STEP_LOOK_O = 4'd8;
    localparam step_t STEP_LOOK_C = 4'd9;
    localparam step_t STEP_OUT    = 4'd10;

    // accumulator range that maps into eight bits
    localparam acc_t SAT_MAX = 32'sd32767;
    localparam acc_t SAT_MIN = -32'sd32768;

    // saturate, else keep sign plus bits 14..8
    function automatic data_t quantise(input acc_t v);
        data_t q;
        if (v > SAT_MAX) begin
            q = data_t'(127);
        end else if (v < SAT_MIN) begin
            q = data_t'(-128);
        end else begin
            q = {v[31], v[14:8]};
        end
        return q;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/lstm_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lstm_ctrl
    import lstm_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  wire   start,
    output logic  busy,
    output step_t step
);

    ctrl_state_t state;
    logic        last_step;

    assign last_step = (step == step_t'(CTRL_STEPS - 1));
    assign busy      = (state == BUSY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    step <= '0;
                    // start is ignored once running
                    if (start) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (last_step) begin
                        state <= IDLE;
                        step  <= '0;
                    end else begin
                        step <= step + 4'd1;
                    end
                end
                default: begin
                    state <= IDLE;
                    step  <= '0;
                end
            endcase
        end
    end

    // counter never runs past the schedule
    step_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        step < step_t'(CTRL_STEPS)
    );

    // idle parks the counter so step decodes stay quiet
    idle_step_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> (step == '0)
    );

endmodule

`default_nettype wire

// ==== verilog/gate_dot.sv ====
`timescale 1ns/1ps
`default_nettype none

module gate_dot
    import lstm_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        busy,
    input  wire step_t step,
    input  wire vec_t  w,
    input  wire vec_t  r,
    input  wire vec_t  x,
    input  wire vec_t  y_prev,
    output acc_t       pre
);

    // partial products of W.x and R.y_prev
    acc_t wx_0;
    acc_t wx_1;
    acc_t wx_2;
    acc_t wx_3;
    acc_t ry_0;
    acc_t ry_1;
    acc_t ry_2;
    acc_t ry_3;

    function automatic acc_t mul(input vec_t a, input vec_t b, input int k);
        data_t ea;
        data_t eb;
        ea = a[8*k +: 8];
        eb = b[8*k +: 8];
        return acc_t'(ea) * acc_t'(eb);
    endfunction

    // two products, then add, per half
    always_ff @(posedge clk) begin
        if (busy) begin
            case (step)
                4'd0: begin
                    wx_0 <= mul(w, x, 0);
                    wx_1 <= mul(w, x, 1);
                    ry_0 <= mul(r, y_prev, 0);
                    ry_1 <= mul(r, y_prev, 1);
                end
                4'd1: begin
                    wx_0 <= wx_0 + wx_1;
                    ry_0 <= ry_0 + ry_1;
                    wx_2 <= mul(w, x, 2);
                    wx_3 <= mul(w, x, 3);
                    ry_2 <= mul(r, y_prev, 2);
                    ry_3 <= mul(r, y_prev, 3);
                end
                4'd2: begin
                    wx_2 <= wx_2 + wx_3;
                    ry_2 <= ry_2 + ry_3;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre <= '0;
        end else if (busy) begin
            if (step == 4'd0) begin
                pre <= '0;
            end else if (step == 4'd3) begin
                // both dot products together
                pre <= wx_0 + wx_2 + ry_0 + ry_2;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/activation_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module activation_seq
    import lstm_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        busy,
    input  wire step_t step,
    input  wire acc_t  pre_i,
    input  wire acc_t  pre_z,
    input  wire acc_t  pre_f,
    input  wire acc_t  pre_o,
    input  wire acc_t  c,
    input  wire data_t p_i,
    input  wire data_t p_f,
    input  wire data_t p_o,
    input  wire data_t act_res,
    output logic       act_req,
    output data_t      act_arg,
    output data_t      act_i,
    output data_t      act_z,
    output data_t      act_f,
    output data_t      act_o,
    output data_t      act_c
);

    // peephole terms
    acc_t peep_i;
    acc_t peep_f;
    acc_t peep_o;

    assign peep_i = acc_t'(p_i) * c;
    assign peep_f = acc_t'(p_f) * c;
    // c has already taken its new value by STEP_LOOK_O
    assign peep_o = acc_t'(p_o) * c;

    // one lookup per step over a single channel
    always_comb begin
        act_req = 1'b0;
        act_arg = '0;
        case (step)
            STEP_LOOK_I: begin
                act_req = 1'b1;
                act_arg = quantise(pre_i + peep_i);
            end
            STEP_LOOK_Z: begin
                act_req = 1'b1;
                act_arg = quantise(pre_z);
            end
            STEP_LOOK_F: begin
                act_req = 1'b1;
                act_arg = quantise(pre_f + peep_f);
            end
            STEP_LOOK_O: begin
                act_req = 1'b1;
                act_arg = quantise(pre_o + peep_o);
            end
            STEP_LOOK_C: begin
                act_req = 1'b1;
                act_arg = quantise(c);
            end
            default: ;
        endcase
    end

    // lookup answers in the same cycle, so capture at the step's end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_i <= '0;
            act_z <= '0;
            act_f <= '0;
            act_o <= '0;
            act_c <= '0;
        end else if (busy) begin
            case (step)
                STEP_LOOK_I: act_i <= act_res;
                STEP_LOOK_Z: act_z <= act_res;
                STEP_LOOK_F: act_f <= act_res;
                STEP_LOOK_O: act_o <= act_res;
                STEP_LOOK_C: act_c <= act_res;
                default: ;
            endcase
        end
    end

    // decode is on step alone, relies on controller parking step at 0
    req_only_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        act_req |-> busy
    );

endmodule

`default_nettype wire

// ==== verilog/cell_update.sv ====
`timescale 1ns/1ps
`default_nettype none

module cell_update
    import lstm_pkg::*;
#(
    parameter int FRAC_SHIFT = 7
)
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        busy,
    input  wire step_t step,
    input  wire data_t act_i,
    input  wire data_t act_z,
    input  wire data_t act_f,
    input  wire data_t act_o,
    input  wire data_t act_c,
    output acc_t       c,
    output data_t      y,
    output logic       valid
);

    acc_t c_next;
    acc_t y_full;
    logic do_cell;
    logic do_out;

    assign do_cell = busy && (step == STEP_CELL);
    assign do_out  = busy && (step == STEP_OUT);

    // f*c + i*z, back to the operand scale
    assign c_next = (acc_t'(act_f) * c + acc_t'(act_i) * acc_t'(act_z)) >>> FRAC_SHIFT;

    assign y_full = (acc_t'(act_o) * acc_t'(act_c)) >>> FRAC_SHIFT;

    // c carries over between runs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c <= '0;
        end else if (do_cell) begin
            c <= c_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y     <= '0;
            valid <= 1'b0;
        end else begin
            valid <= do_out;
            // y holds until the next run ends
            if (do_out) begin
                y <= y_full[7:0];
            end
        end
    end

    // one step of the schedule per run, so never back to back
    valid_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid |=> !valid
    );

endmodule

`default_nettype wire

// ==== verilog/lstm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lstm_top
    import lstm_pkg::*;
#(
    parameter int FRAC_SHIFT = 7
)
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        start,
    input  wire vec_t  x,
    input  wire vec_t  y_prev,
    input  wire vec_t  w_i,
    input  wire vec_t  w_z,
    input  wire vec_t  w_f,
    input  wire vec_t  w_o,
    input  wire vec_t  r_i,
    input  wire vec_t  r_z,
    input  wire vec_t  r_f,
    input  wire vec_t  r_o,
    input  wire data_t p_i,
    input  wire data_t p_f,
    input  wire data_t p_o,
    input  wire data_t act_res,
    output logic       busy,
    output logic       valid,
    output data_t      y,
    output logic       act_req,
    output data_t      act_arg
);

    step_t step;
    acc_t  pre_i;
    acc_t  pre_z;
    acc_t  pre_f;
    acc_t  pre_o;
    acc_t  c;
    data_t act_i;
    data_t act_z;
    data_t act_f;
    data_t act_o;
    data_t act_c;

    lstm_ctrl ctrl_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .busy  (busy),
        .step  (step)
    );

    // one unit per gate, inputs shared
    gate_dot gate_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .busy   (busy),
        .step   (step),
        .w      (w_i),
        .r      (r_i),
        .x      (x),
        .y_prev (y_prev),
        .pre    (pre_i)
    );

    gate_dot gate_z (
        .clk    (clk),
        .rst_n  (rst_n),
        .busy   (busy),
        .step   (step),
        .w      (w_z),
        .r      (r_z),
        .x      (x),
        .y_prev (y_prev),
        .pre    (pre_z)
    );

    gate_dot gate_f (
        .clk    (clk),
        .rst_n  (rst_n),
        .busy   (busy),
        .step   (step),
        .w      (w_f),
        .r      (r_f),
        .x      (x),
        .y_prev (y_prev),
        .pre    (pre_f)
    );

    gate_dot gate_o (
        .clk    (clk),
        .rst_n  (rst_n),
        .busy   (busy),
        .step   (step),
        .w      (w_o),
        .r      (r_o),
        .x      (x),
        .y_prev (y_prev),
        .pre    (pre_o)
    );

    activation_seq act_seq_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .busy    (busy),
        .step    (step),
        .pre_i   (pre_i),
        .pre_z   (pre_z),
        .pre_f   (pre_f),
        .pre_o   (pre_o),
        .c       (c),
        .p_i     (p_i),
        .p_f     (p_f),
        .p_o     (p_o),
        .act_res (act_res),
        .act_req (act_req),
        .act_arg (act_arg),
        .act_i   (act_i),
        .act_z   (act_z),
        .act_f   (act_f),
        .act_o   (act_o),
        .act_c   (act_c)
    );

    cell_update #(
        .FRAC_SHIFT (FRAC_SHIFT)
    ) cell_i (
        .clk   (clk),
        .rst_n (rst_n),
        .busy  (busy),
        .step  (step),
        .act_i (act_i),
        .act_z (act_z),
        .act_f (act_f),
        .act_o (act_o),
        .act_c (act_c),
        .c     (c),
        .y     (y),
        .valid (valid)
    );

endmodule

`default_nettype wire

// ==== tests/lstm_model.svh ====
`ifndef LSTM_MODEL_SVH
`define LSTM_MODEL_SVH

// saturate outside the 16-bit range, else sign plus bits 14..8
function automatic data_t to_eight_bits(input acc_t v);
    data_t q;
    if (v > 32767) begin
        q = 8'sh7f;
    end else if (v < -32768) begin
        q = 8'sh80;
    end else begin
        q[7]   = v[31];
        q[6:0] = v[14:8];
    end
    return q;
endfunction

// same rule as the external responder
function automatic data_t lookup_value(input data_t arg);
    return (arg >>> 1) + 8'sd64;
endfunction

// W.x + R.y_prev for one gate
function automatic acc_t gate_sum(input vec_t w, input vec_t r, input vec_t x, input vec_t yp);
    acc_t  sum;
    data_t a;
    data_t b;
    int    k;
    sum = 0;
    for (k = 0; k < 4; k++) begin
        a   = w[8*k +: 8];
        b   = x[8*k +: 8];
        sum = sum + acc_t'(a) * acc_t'(b);
        a   = r[8*k +: 8];
        b   = yp[8*k +: 8];
        sum = sum + acc_t'(a) * acc_t'(b);
    end
    return sum;
endfunction

// one cell step, gate order i z f o, peepholes i f o
function automatic data_t cell_step(
    input  vec_t  [3:0] w,
    input  vec_t  [3:0] r,
    input  vec_t        x,
    input  vec_t        yp,
    input  data_t [2:0] p,
    input  int          shift,
    inout  acc_t        c,
    output data_t [4:0] args
);
    data_t act_i;
    data_t act_z;
    data_t act_f;
    data_t act_o;
    data_t act_c;
    acc_t  prod;
    args[0] = to_eight_bits(gate_sum(w[0], r[0], x, yp) + acc_t'(p[0]) * c);
    act_i   = lookup_value(args[0]);
    args[1] = to_eight_bits(gate_sum(w[1], r[1], x, yp));
    act_z   = lookup_value(args[1]);
    args[2] = to_eight_bits(gate_sum(w[2], r[2], x, yp) + acc_t'(p[1]) * c);
    act_f   = lookup_value(args[2]);
    c       = (acc_t'(act_f) * c + acc_t'(act_i) * acc_t'(act_z)) >>> shift;
    // output gate sees the new c
    args[3] = to_eight_bits(gate_sum(w[3], r[3], x, yp) + acc_t'(p[2]) * c);
    act_o   = lookup_value(args[3]);
    args[4] = to_eight_bits(c);
    act_c   = lookup_value(args[4]);
    prod    = (acc_t'(act_o) * acc_t'(act_c)) >>> shift;
    return prod[7:0];
endfunction

`endif

// ==== tests/tb_lstm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lstm
    import lstm_pkg::*;
();

    localparam int FRAC_SHIFT  = 7;
    localparam int CYCLE_LIMIT = 40 * 14 + 50;

    logic        clk;
    logic        rst_n;
    logic        start;
    vec_t        x;
    vec_t        y_prev;
    vec_t  [3:0] w;
    vec_t  [3:0] r;
    data_t [2:0] p;
    data_t       act_res;
    logic        busy;
    logic        valid;
    logic        act_req;
    data_t       y;
    data_t       act_arg;

    integer      seed;
    int          errors;
    int          cycles = 0;
    acc_t        model_c;

    // expectations for the next run, taken over when start is sampled
    data_t       next_y;
    data_t [4:0] next_args;
    logic        next_sat;
    data_t       next_sat_arg;

    logic        started;
    logic        exp_busy;
    logic        exp_valid;
    step_t       exp_step;
    data_t       exp_y;
    data_t [4:0] exp_args;
    logic        sat_check;
    data_t       sat_arg;
    int          req_count;
    logic        want_req;
    data_t       want_arg;

    `include "lstm_model.svh"

    lstm_top #(
        .FRAC_SHIFT (FRAC_SHIFT)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .x       (x),
        .y_prev  (y_prev),
        .w_i     (w[0]),
        .w_z     (w[1]),
        .w_f     (w[2]),
        .w_o     (w[3]),
        .r_i     (r[0]),
        .r_z     (r[1]),
        .r_f     (r[2]),
        .r_o     (r[3]),
        .p_i     (p[0]),
        .p_f     (p[1]),
        .p_o     (p[2]),
        .act_res (act_res),
        .busy    (busy),
        .valid   (valid),
        .y       (y),
        .act_req (act_req),
        .act_arg (act_arg)
    );

    // lookup responder, answers in the same cycle
    always_comb begin
        act_res = act_req ? (act_arg >>> 1) + 8'sd64 : 8'sd0;
    end

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // schedule tracker
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started   <= 1'b0;
            exp_busy  <= 1'b0;
            exp_valid <= 1'b0;
            exp_step  <= '0;
            req_count <= 0;
        end else begin
            exp_valid <= exp_busy && (exp_step == STEP_OUT);
            if (act_req) begin
                req_count <= req_count + 1;
            end
            if (!exp_busy) begin
                if (start) begin
                    started   <= 1'b1;
                    exp_busy  <= 1'b1;
                    exp_step  <= '0;
                    req_count <= 0;
                    exp_y     <= next_y;
                    exp_args  <= next_args;
                    sat_check <= next_sat;
                    sat_arg   <= next_sat_arg;
                end
            end else if (exp_step == STEP_OUT) begin
                exp_busy <= 1'b0;
                exp_step <= '0;
            end else begin
                exp_step <= exp_step + 4'd1;
            end
        end
    end

    always_comb begin
        want_req = 1'b0;
        want_arg = 8'sd0;
        if (exp_busy) begin
            want_req = 1'b1;
            case (exp_step)
                STEP_LOOK_I: want_arg = exp_args[0];
                STEP_LOOK_Z: want_arg = exp_args[1];
                STEP_LOOK_F: want_arg = exp_args[2];
                STEP_LOOK_O: want_arg = exp_args[3];
                STEP_LOOK_C: want_arg = exp_args[4];
                default: want_req = 1'b0;
            endcase
        end
    end

    idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!busy && !valid && !act_req && y == 8'sd0))
        else begin
            errors++;
            $display("MISMATCH at %0t: outputs active before the first start", $time);
        end

    busy_on_schedule: assert property (@(posedge clk) disable iff (!rst_n)
        busy == exp_busy)
        else begin
            errors++;
            $display("MISMATCH at %0t: busy is %0b, expected %0b", $time,
                     $sampled(busy), $sampled(exp_busy));
        end

    valid_on_schedule: assert property (@(posedge clk) disable iff (!rst_n)
        valid == exp_valid)
        else begin
            errors++;
            $display("MISMATCH at %0t: valid is %0b, expected %0b", $time,
                     $sampled(valid), $sampled(exp_valid));
        end

    req_on_schedule: assert property (@(posedge clk) disable iff (!rst_n)
        act_req == want_req)
        else begin
            errors++;
            $display("MISMATCH at %0t: act_req at step %0d", $time, $sampled(exp_step));
        end

    arg_matches: assert property (@(posedge clk) disable iff (!rst_n)
        want_req |-> act_arg == want_arg)
        else begin
            errors++;
            $display("MISMATCH at %0t: act_arg %0d, expected %0d", $time,
                     $sampled(act_arg), $sampled(want_arg));
        end

    // large weights pin the first lookup to a rail
    sat_arg_exact: assert property (@(posedge clk) disable iff (!rst_n)
        (sat_check && want_req && exp_step == STEP_LOOK_I) |-> act_arg == sat_arg)
        else begin
            errors++;
            $display("MISMATCH at %0t: saturated act_arg %0d, expected %0d", $time,
                     $sampled(act_arg), $sampled(sat_arg));
        end

    five_lookups: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> req_count == 5)
        else begin
            errors++;
            $display("MISMATCH at %0t: %0d lookups in the run", $time, $sampled(req_count));
        end

    y_matches: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> y == exp_y)
        else begin
            errors++;
            $display("MISMATCH at %0t: y %0d, expected %0d", $time,
                     $sampled(y), $sampled(exp_y));
        end

    y_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !valid |-> $stable(y))
        else begin
            errors++;
            $display("MISMATCH at %0t: y changed without valid", $time);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the test did not finish", cycles);
            $display("errors: %0d", errors);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic data_t small_value();
        return data_t'($random(seed) % 32);
    endfunction

    function automatic vec_t small_vec();
        return {small_value(), small_value(), small_value(), small_value()};
    endfunction

    task automatic random_operands();
        int g;
        x      = small_vec();
        y_prev = small_vec();
        for (g = 0; g < 4; g++) begin
            w[g] = small_vec();
            r[g] = small_vec();
        end
        p        = {small_value(), small_value(), small_value()};
        next_sat = 1'b0;
    endtask

    // input gate driven far past the 16-bit range
    task automatic saturating_operands(input logic opposing);
        random_operands();
        x            = {4{8'h7f}};
        y_prev       = {4{8'h7f}};
        w[0]         = opposing ? {4{8'h80}} : {4{8'h7f}};
        r[0]         = w[0];
        p[0]         = 8'sd0;
        next_sat     = 1'b1;
        next_sat_arg = opposing ? 8'sh80 : 8'sh7f;
    endtask

    task automatic wait_for_valid();
        int n;
        n = 0;
        while (!valid && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!valid) begin
            errors++;
            $display("no valid pulse within 20 cycles of start at %0t", $time);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_once(input logic extra_start);
        next_y = cell_step(w, r, x, y_prev, p, FRAC_SHIFT, model_c, next_args);
        start  = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        if (extra_start) begin
            // second start in the middle of the run
            repeat (4) @(posedge clk);
            #1 start = 1'b1;
            @(posedge clk);
            #1 start = 1'b0;
        end
        wait_for_valid();
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        model_c = 0;
    endtask

    initial begin
        int k;
        seed         = 32'h37f0_7124;
        errors       = 0;
        model_c      = 0;
        rst_n        = 1'b1;
        start        = 1'b0;
        x            = '0;
        y_prev       = '0;
        w            = '0;
        r            = '0;
        p            = '0;
        next_y       = 8'sd0;
        next_args    = '0;
        next_sat     = 1'b0;
        next_sat_arg = 8'sd0;
        #1;
        apply_reset();
        repeat (3) @(posedge clk);
        #1;
        repeat (18) begin
            random_operands();
            run_once(1'b0);
        end
        for (k = 0; k < 4; k++) begin
            saturating_operands(k[0]);
            run_once(1'b0);
        end
        // same inputs each time, only the carried c moves y
        random_operands();
        repeat (6) run_once(1'b0);
        apply_reset();
        repeat (2) @(posedge clk);
        #1;
        repeat (3) begin
            random_operands();
            run_once(1'b0);
        end
        repeat (3) begin
            random_operands();
            run_once(1'b1);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+tests
verilog/lstm_pkg.sv
verilog/lstm_ctrl.sv
verilog/gate_dot.sv
verilog/activation_seq.sv
verilog/cell_update.sv
verilog/lstm_top.sv
tests/tb_lstm.sv

// ==== Makefile ====
SRCS := $(shell grep '\.sv$$' filelist.f)

obj_dir/Vtb_lstm: filelist.f $(SRCS) tests/lstm_model.svh
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_lstm -f filelist.f

run: obj_dir/Vtb_lstm
	./obj_dir/Vtb_lstm | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
